//--- fm_chip_pkg.sv
// chip-side definitions for the FM register path
// register numbers, update kinds, divider settings and busy length
package fm_chip_pkg;

    // global registers, bank 0 numbering
    localparam logic [7:0] REG_TEST    = 8'h21;
    localparam logic [7:0] REG_LFO     = 8'h22;
    localparam logic [7:0] REG_CLKA1   = 8'h24;
    localparam logic [7:0] REG_CLKA2   = 8'h25;
    localparam logic [7:0] REG_CLKB    = 8'h26;
    localparam logic [7:0] REG_TIMER   = 8'h27;
    localparam logic [7:0] REG_KON     = 8'h28;
    localparam logic [7:0] REG_PCM     = 8'h2A;
    localparam logic [7:0] REG_PCM_EN  = 8'h2B;
    localparam logic [7:0] REG_DACTEST = 8'h2C;
    localparam logic [7:0] REG_CLK_N6  = 8'h2D;
    localparam logic [7:0] REG_CLK_N3  = 8'h2E;
    localparam logic [7:0] REG_CLK_N2  = 8'h2F;

    // kind of per-slot update sent to the parameter store
    typedef enum logic [3:0] {
        UPD_NONE    = 4'd0,
        UPD_FNUM    = 4'd1,  // fnum low, block/fnum high rides along
        UPD_ALG_FB  = 4'd2,
        UPD_PMS_AMS = 4'd3,
        UPD_DT_MUL  = 4'd4,
        UPD_TL      = 4'd5,
        UPD_KS_AR   = 4'd6,
        UPD_AM_DR   = 4'd7,
        UPD_SR      = 4'd8,
        UPD_SL_RR   = 4'd9,
        UPD_SSG_EG  = 4'd10,
        UPD_KEYON   = 4'd11
    } upd_kind_t;

    // prescaler selection, 01 is not a valid setting
    typedef enum logic [1:0] {
        DIV_2 = 2'b00,
        DIV_6 = 2'b10,
        DIV_3 = 2'b11
    } div_sel_t;

    localparam int BUSY_ENABLES = 32; // chip enables per data write

endpackage

//--- fm_bus_pkg.sv
// bus-side definitions for the FM register path
// AXI4-Lite response codes, slot decoding and record queue sizing
package fm_bus_pkg;

    localparam int AXI_ADDR_W = 4;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // address bits that pick bank and slot
    localparam int PORT_BIT = 3;
    localparam int SLOT_BIT = 2; // 0 address slot, 1 data slot

    localparam int QUEUE_DEPTH = 8;
    localparam int LEVEL_W     = 4; // holds 0 to QUEUE_DEPTH

    // one host write as seen by the chip
    typedef struct packed {
        logic       port;    // bank, channels 0-2 or 3-5
        logic       is_data; // data slot write
        logic [7:0] value;   // register number or data byte
    } reg_wr_t;

endpackage

//--- reg_write_if.sv
// register-write record link with valid/ready handshake
// src drives records, snk accepts them
interface reg_write_if import fm_bus_pkg::*; ();

    logic    valid;
    logic    ready;
    reg_wr_t rec;

    modport src (
        output valid,
        output rec,
        input  ready
    );

    modport snk (
        input  valid,
        input  rec,
        output ready
    );

endinterface

//--- axil_reg_port.sv
// AXI4-Lite slave front end that turns each accepted write into a record
// reads return the status byte
module axil_reg_port import fm_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // write address and data
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    // write response
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    // read
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    // status sources
    input  logic                  busy,
    input  logic [LEVEL_W-1:0]    level,
    input  logic                  full,
    reg_write_if.src              wr
);

    logic wr_accept;
    logic rd_accept;
    logic [7:0] status;

    // address and data arrive together with one write in flight
    assign wr_accept = awvalid && wvalid && !bvalid && wr.ready;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    // lane 0 carries the byte and a write without it makes no record
    assign wr.valid       = awvalid && wvalid && !bvalid && wstrb[0];
    assign wr.rec.port    = awaddr[PORT_BIT];
    assign wr.rec.is_data = awaddr[SLOT_BIT];
    assign wr.rec.value   = wdata[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
            bresp  <= wstrb[0] ? RESP_OKAY : RESP_SLVERR;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign status = {busy, full, 2'b00, level};

    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // read payload taken with the address
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= {24'h0, status};
            // misaligned read gets an error but still returns the status
            rresp <= (araddr[1:0] == 2'b00) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // response must be held until the host takes it
    assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid);

endmodule

//--- reg_write_queue.sv
// record FIFO between bus front end and decoder
// back-pressures the bus when full, level goes to the status byte
module reg_write_queue import fm_bus_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    reg_write_if.snk           in,
    reg_write_if.src           out,
    output logic [LEVEL_W-1:0] level,
    output logic               full
);

    reg_wr_t mem [QUEUE_DEPTH];

    logic [LEVEL_W-2:0] wr_ptr; // wraps at QUEUE_DEPTH
    logic [LEVEL_W-2:0] rd_ptr;
    logic [LEVEL_W-1:0] count;
    logic push;
    logic pop;

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in.rec;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // none or both
            endcase
        end
    end

    assign full      = (count == LEVEL_W'(QUEUE_DEPTH));
    assign level     = count;
    assign in.ready  = !full;
    assign out.valid = (count != '0);
    assign out.rec   = mem[rd_ptr]; // head, visible the cycle after push

    // a full queue only drains, never overflows
    assert property (@(posedge clk) disable iff (rst)
        full && !pop |=> count == $past(count));

endmodule

//--- chip_clk_div.sv
// prescaler for the chip clock enable, one pulse every 6, 3 or 2 clk
module chip_clk_div import fm_chip_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  div_sel_t div,
    output logic     ce
);

    logic [2:0] cnt;
    logic [2:0] reload;

    always_comb begin
        case (div)
            DIV_2:   reload = 3'd1;
            DIV_3:   reload = 3'd2;
            default: reload = 3'd5; // DIV_6
        endcase
    end

    // new setting is picked up at the next reload
    always_ff @(posedge clk) begin
        if (rst)
            cnt <= '0;
        else if (cnt == '0)
            cnt <= reload;
        else
            cnt <= cnt - 1'b1;
    end

    assign ce = (cnt == '0);

endmodule

//--- reg_decoder.sv
// chip register decoder, applies records to the global registers,
// sends per-slot update strobes and runs busy and the prescaler
module reg_decoder import fm_chip_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    reg_write_if.snk   wr,
    output logic       busy,
    // test bits
    output logic       eg_stop,
    output logic       pg_stop,
    output logic       fast_timers,
    // LFO
    output logic       lfo_en,
    output logic [2:0] lfo_freq,
    // timers
    output logic [9:0] value_a,
    output logic [7:0] value_b,
    output logic       load_a,
    output logic       load_b,
    output logic       irq_en_a,
    output logic       irq_en_b,
    output logic       clr_flag_a,
    output logic       clr_flag_b,
    output logic       csm,
    output logic       effect,
    // PCM
    output logic [8:0] pcm,
    output logic       pcm_en,
    // update strobe to the parameter store
    output logic       upd_valid,
    output upd_kind_t  upd_kind,
    output logic [2:0] upd_ch,
    output logic [1:0] upd_op,
    output logic [7:0] upd_data,
    output logic [5:0] upd_fnum_hi
);

    logic [7:0] sel_reg; // register picked by the last address write
    logic [5:0] fnum_latch;
    logic [$clog2(BUSY_ENABLES)-1:0] busy_cnt;
    div_sel_t div;
    upd_kind_t kind;
    logic ce;
    logic hs;
    logic data_hs;
    logic [7:0] din;

    chip_clk_div u_div (
        .clk (clk),
        .rst (rst),
        .div (div),
        .ce  (ce)
    );

    // data records wait while busy, address records always pass
    assign wr.ready = !wr.rec.is_data || !busy;
    assign hs       = wr.valid && wr.ready;
    assign data_hs  = hs && wr.rec.is_data;
    assign din      = wr.rec.value;

    always_comb begin
        kind = UPD_NONE;
        if (sel_reg[1:0] != 2'b11) begin // slot 3 of a group does not exist
            casez (sel_reg)
                REG_KON:             kind = UPD_KEYON;
                8'h3?:               kind = UPD_DT_MUL;
                8'h4?:               kind = UPD_TL;
                8'h5?:               kind = UPD_KS_AR;
                8'h6?:               kind = UPD_AM_DR;
                8'h7?:               kind = UPD_SR;
                8'h8?:               kind = UPD_SL_RR;
                8'h9?:               kind = UPD_SSG_EG;
                8'hA0, 8'hA1, 8'hA2: kind = UPD_FNUM;
                8'hB0, 8'hB1, 8'hB2: kind = UPD_ALG_FB;
                8'hB4, 8'hB5, 8'hB6: kind = UPD_PMS_AMS;
                default:             kind = UPD_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg     <= 8'h00;
            div         <= DIV_6;
            fnum_latch  <= 6'd0;
            {eg_stop, pg_stop, fast_timers} <= 3'b000;
            {lfo_en, lfo_freq} <= 4'h0;
            value_a     <= 10'd0;
            value_b     <= 8'd0;
            {clr_flag_b, clr_flag_a, irq_en_b, irq_en_a, load_b, load_a} <= 6'd0;
            csm         <= 1'b0;
            effect      <= 1'b0;
            pcm         <= 9'd0;
            pcm_en      <= 1'b0;
        end else begin
            if (ce)
                {clr_flag_b, clr_flag_a} <= 2'b00; // one-shot, a write below wins
            if (hs && !wr.rec.is_data)
                sel_reg <= din;
            if (data_hs) begin
                case (sel_reg)
                    REG_TEST: begin
                        eg_stop     <= din[5];
                        pg_stop     <= din[3];
                        fast_timers <= din[2];
                    end
                    REG_LFO:     {lfo_en, lfo_freq} <= din[3:0];
                    REG_CLKA1:   value_a[9:2] <= din;
                    REG_CLKA2:   value_a[1:0] <= din[1:0];
                    REG_CLKB:    value_b <= din;
                    REG_TIMER: begin
                        effect <= |din[7:6];
                        csm    <= (din[7:6] == 2'b10);
                        {clr_flag_b, clr_flag_a, irq_en_b, irq_en_a, load_b, load_a} <= din[5:0];
                    end
                    REG_PCM:     pcm[8:1] <= din;
                    REG_DACTEST: pcm[0] <= din[3];
                    REG_PCM_EN:  pcm_en <= din[7];
                    REG_CLK_N6:  div <= (div == DIV_3) ? DIV_3 : DIV_6;
                    REG_CLK_N3:  div <= DIV_3;
                    REG_CLK_N2:  div <= DIV_2;
                    // one high latch shared by all channels
                    8'hA4, 8'hA5, 8'hA6, 8'hAC, 8'hAD, 8'hAE: fnum_latch <= din[5:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            upd_valid <= 1'b0;
        else
            upd_valid <= data_hs && (kind != UPD_NONE);
    end

    // strobe payload
    always_ff @(posedge clk) begin
        if (data_hs && kind != UPD_NONE) begin
            upd_kind    <= kind;
            upd_op      <= sel_reg[3:2];
            upd_data    <= din;
            upd_fnum_hi <= fnum_latch;
            if (kind == UPD_KEYON)
                upd_ch <= din[2:0]; // bit 2 picks the bank
            else
                upd_ch <= {wr.rec.port, sel_reg[1:0]};
        end
    end

    // busy for BUSY_ENABLES chip clocks after each data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_hs) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (ce && busy) begin
            if (busy_cnt == $bits(busy_cnt)'(BUSY_ENABLES - 1))
                busy <= 1'b0;
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        upd_valid |-> upd_kind != UPD_NONE);

    assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(data_hs));

endmodule

//--- fm_reg_top.sv
// FM chip register write path, AXI4-Lite in, global registers and
// update strobes out
module fm_reg_top import fm_chip_pkg::*, fm_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  busy,
    output logic                  eg_stop,
    output logic                  pg_stop,
    output logic                  fast_timers,
    output logic                  lfo_en,
    output logic [2:0]            lfo_freq,
    output logic [9:0]            value_a,
    output logic [7:0]            value_b,
    output logic                  load_a,
    output logic                  load_b,
    output logic                  irq_en_a,
    output logic                  irq_en_b,
    output logic                  clr_flag_a,
    output logic                  clr_flag_b,
    output logic                  csm,
    output logic                  effect,
    output logic [8:0]            pcm,
    output logic                  pcm_en,
    output logic                  upd_valid,
    output upd_kind_t             upd_kind,
    output logic [2:0]            upd_ch,
    output logic [1:0]            upd_op,
    output logic [7:0]            upd_data,
    output logic [5:0]            upd_fnum_hi
);

    logic [LEVEL_W-1:0] level;
    logic               full;

    reg_write_if bus_wr ();
    reg_write_if dec_wr ();

    axil_reg_port u_port (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .busy, .level, .full,
        .wr (bus_wr)
    );

    reg_write_queue u_queue (
        .clk, .rst,
        .in    (bus_wr),
        .out   (dec_wr),
        .level (level),
        .full  (full)
    );

    reg_decoder u_dec (
        .clk, .rst,
        .wr (dec_wr),
        .busy, .eg_stop, .pg_stop, .fast_timers, .lfo_en, .lfo_freq,
        .value_a, .value_b, .load_a, .load_b, .irq_en_a, .irq_en_b,
        .clr_flag_a, .clr_flag_b, .csm, .effect, .pcm, .pcm_en,
        .upd_valid, .upd_kind, .upd_ch, .upd_op, .upd_data, .upd_fnum_hi
    );

endmodule

//--- tb_fm_reg.sv
// self-checking testbench for the FM register write path
// replays a table of register writes over AXI4-Lite and checks globals and strobes
module tb_fm_reg import fm_chip_pkg::*, fm_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS    = 25;
    localparam int ROW_CYCLES  = 6 * BUSY_ENABLES + 40;
    localparam int CYCLE_LIMIT = NUM_ROWS * ROW_CYCLES + 3000; // margin for the extra tests

    typedef struct packed {
        logic        burst;  // issue without waiting for busy
        logic        port;
        logic [7:0]  regn;
        logic [7:0]  data;
        upd_kind_t   kind;   // UPD_NONE when no strobe is expected
        logic [2:0]  ch;
        logic [1:0]  op;
        logic [5:0]  fhi;
        logic [3:0]  gsel;   // global output to compare or 0 for none
        logic [11:0] gexp;
    } row_t;

    typedef struct packed {
        upd_kind_t  kind;
        logic [2:0] ch;
        logic [1:0] op;
        logic [7:0] data;
        logic [5:0] fhi;
    } strobe_t;

    logic clk, rst;
    logic [AXI_ADDR_W-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic busy, eg_stop, pg_stop, fast_timers, lfo_en, pcm_en;
    logic [2:0] lfo_freq;
    logic [9:0] value_a;
    logic [7:0] value_b;
    logic load_a, load_b, irq_en_a, irq_en_b, clr_flag_a, clr_flag_b, csm, effect;
    logic [8:0] pcm;
    logic upd_valid;
    upd_kind_t upd_kind;
    logic [2:0] upd_ch;
    logic [1:0] upd_op;
    logic [7:0] upd_data;
    logic [5:0] upd_fnum_hi;

    row_t rows [NUM_ROWS];
    strobe_t exp_q [$];
    strobe_t obs_q [$];
    logic [1:0] clr_seen; // {b, a} seen high since the row started
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int failed = 0;

    fm_reg_top uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // strobes last one clk so one negedge sees each
    always @(negedge clk) begin
        strobe_t s;
        if (!rst && upd_valid) begin
            s = '{upd_kind, upd_ch, upd_op, upd_data, upd_fnum_hi};
            obs_q.push_back(s);
        end
        if (clr_flag_a)
            clr_seen[0] = 1'b1;
        if (clr_flag_b)
            clr_seen[1] = 1'b1;
    end

    task automatic check(input string what, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, what, act, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before)
            failed++;
        $display("test %s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic axi_write(input logic port, input logic slot, input logic [7:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int gap;
        gap = $urandom % 3; // bready stall
        @(negedge clk);
        awaddr  <= {port, slot, 2'b00};
        wdata   <= {24'h0, data};
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        #5;
        while (!awready) begin
            @(negedge clk);
            #5;
        end
        @(negedge clk); // taken on the edge just passed
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (gap) @(negedge clk);
        bready <= 1'b1;
        #5;
        while (!bvalid) begin
            @(negedge clk);
            #5;
        end
        resp = bresp;
        @(negedge clk);
        bready <= 1'b0;
    endtask

    task automatic status_read(output logic [7:0] st);
        int gap;
        gap = $urandom % 3; // rready stall
        @(negedge clk);
        araddr  <= '0;
        arvalid <= 1'b1;
        #5;
        while (!arready) begin
            @(negedge clk);
            #5;
        end
        @(negedge clk);
        arvalid <= 1'b0;
        repeat (gap) @(negedge clk);
        rready <= 1'b1;
        #5;
        while (!rvalid) begin
            @(negedge clk);
            #5;
        end
        st = rdata[7:0];
        check("rresp", rresp, RESP_OKAY);
        @(negedge clk);
        rready <= 1'b0;
    endtask

    // address slot then data slot of one port
    task automatic write_register(input logic port, input logic [7:0] regn,
                                  input logic [7:0] data);
        logic [1:0] resp;
        axi_write(port, 1'b0, regn, 4'h1, resp);
        check("bresp address slot", resp, RESP_OKAY);
        axi_write(port, 1'b1, data, 4'h1, resp);
        check("bresp data slot", resp, RESP_OKAY);
    endtask

    // wait for an empty queue and busy low with every record applied
    task automatic wait_idle();
        logic [7:0] st;
        st = 8'hFF;
        while (st[7] || st[3:0] != 4'd0)
            status_read(st);
    endtask

    task automatic measure_busy(output int len);
        len = 0;
        @(negedge clk);
        while (!busy)
            @(negedge clk);
        while (busy) begin
            len++;
            @(negedge clk);
        end
    endtask

    task automatic compare_strobes();
        strobe_t e;
        strobe_t o;
        check("strobe count", obs_q.size(), exp_q.size());
        while (exp_q.size() > 0 && obs_q.size() > 0) begin
            e = exp_q.pop_front();
            o = obs_q.pop_front();
            check("upd_kind", o.kind, e.kind);
            check("upd_ch", o.ch, e.ch);
            check("upd_op", o.op, e.op);
            check("upd_data", o.data, e.data);
            if (e.kind == UPD_FNUM)
                check("upd_fnum_hi", o.fhi, e.fhi);
        end
        exp_q.delete();
        obs_q.delete();
    endtask

    function automatic logic [11:0] global_out(input logic [3:0] sel);
        case (sel)
            4'd1:    return 12'(value_a);
            4'd2:    return 12'(value_b);
            4'd3:    return 12'({lfo_en, lfo_freq});
            4'd4:    return 12'(pcm);
            4'd5:    return 12'({clr_seen, clr_flag_b, clr_flag_a, effect, csm,
                                 irq_en_b, irq_en_a, load_b, load_a});
            4'd6:    return 12'({eg_stop, pg_stop, fast_timers});
            4'd7:    return 12'(pcm_en);
            default: return 12'd0;
        endcase
    endfunction

    task automatic load_table();
        // burst port reg data kind ch op fnum_hi global expected
        rows[0]  = '{1'b0, 1'b0, REG_CLKA1,   8'hA5, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd1, 12'h294};
        rows[1]  = '{1'b0, 1'b0, REG_CLKA2,   8'h03, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd1, 12'h297};
        rows[2]  = '{1'b0, 1'b0, REG_CLKB,    8'h5C, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd2, 12'h05C};
        rows[3]  = '{1'b0, 1'b0, REG_LFO,     8'h0D, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd3, 12'h00D};
        rows[4]  = '{1'b0, 1'b0, REG_PCM,     8'h81, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd4, 12'h102};
        rows[5]  = '{1'b0, 1'b0, REG_DACTEST, 8'h08, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd4, 12'h103};
        rows[6]  = '{1'b0, 1'b0, REG_TIMER,   8'h3F, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd5, 12'h30F};
        rows[7]  = '{1'b0, 1'b0, REG_TIMER,   8'h85, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd5, 12'h035};
        rows[8]  = '{1'b0, 1'b1, 8'h4D,       8'h22, UPD_TL,      3'd5, 2'd3, 6'h00, 4'd0, 12'h000};
        rows[9]  = '{1'b0, 1'b1, 8'h63,       8'h55, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd0, 12'h000};
        rows[10] = '{1'b0, 1'b1, 8'hA5,       8'h2A, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd0, 12'h000};
        rows[11] = '{1'b0, 1'b0, 8'hA1,       8'h9C, UPD_FNUM,    3'd1, 2'd0, 6'h2A, 4'd0, 12'h000};
        rows[12] = '{1'b0, 1'b1, 8'hAD,       8'h11, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd0, 12'h000};
        rows[13] = '{1'b0, 1'b1, 8'hA2,       8'h44, UPD_FNUM,    3'd6, 2'd0, 6'h11, 4'd0, 12'h000};
        rows[14] = '{1'b0, 1'b0, 8'hB1,       8'h3A, UPD_ALG_FB,  3'd1, 2'd0, 6'h00, 4'd0, 12'h000};
        rows[15] = '{1'b0, 1'b0, REG_KON,     8'hF5, UPD_KEYON,   3'd5, 2'd2, 6'h00, 4'd0, 12'h000};
        rows[16] = '{1'b1, 1'b0, 8'h9A,       8'h0B, UPD_SSG_EG,  3'd2, 2'd2, 6'h00, 4'd0, 12'h000};
        rows[17] = '{1'b1, 1'b1, 8'h84,       8'hF7, UPD_SL_RR,   3'd4, 2'd1, 6'h00, 4'd0, 12'h000};
        rows[18] = '{1'b1, 1'b0, 8'h71,       8'h05, UPD_SR,      3'd1, 2'd0, 6'h00, 4'd0, 12'h000};
        rows[19] = '{1'b1, 1'b1, 8'h6C,       8'h8E, UPD_AM_DR,   3'd4, 2'd3, 6'h00, 4'd0, 12'h000};
        rows[20] = '{1'b0, 1'b0, 8'h30,       8'h71, UPD_DT_MUL,  3'd0, 2'd0, 6'h00, 4'd0, 12'h000};
        rows[21] = '{1'b0, 1'b1, 8'hB6,       8'hC0, UPD_PMS_AMS, 3'd6, 2'd1, 6'h00, 4'd0, 12'h000};
        rows[22] = '{1'b0, 1'b0, 8'h56,       8'h1F, UPD_KS_AR,   3'd2, 2'd1, 6'h00, 4'd0, 12'h000};
        rows[23] = '{1'b0, 1'b0, REG_TEST,    8'h24, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd6, 12'h005};
        rows[24] = '{1'b0, 1'b0, REG_PCM_EN,  8'h80, UPD_NONE,    3'd0, 2'd0, 6'h00, 4'd7, 12'h001};
    endtask

    initial begin
        logic [7:0] st;
        logic [1:0] resp;
        strobe_t s;
        int errs;
        int len;
        void'($urandom(32'h85b2_02cd));
        clk = 1'b0;
        rst = 1'b1;
        {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
        {araddr, arvalid, rready} = '0;
        clr_seen = 2'b00;
        load_table();
        repeat (8) @(negedge clk);
        rst <= 1'b0;

        errs = errors;
        check("reset outputs", {bvalid, rvalid, upd_valid, busy, load_a, load_b, irq_en_a,
              irq_en_b, clr_flag_a, clr_flag_b, lfo_en, pcm_en}, 0);
        status_read(st);
        check("status after reset", st, 8'h00);
        report_test("reset values", errs);

        for (int i = 0; i < NUM_ROWS; i++) begin
            errs = errors;
            if (!rows[i].burst)
                wait_idle();
            clr_seen = 2'b00;
            write_register(rows[i].port, rows[i].regn, rows[i].data);
            if (rows[i].kind != UPD_NONE) begin
                s = '{rows[i].kind, rows[i].ch, rows[i].op, rows[i].data, rows[i].fhi};
                exp_q.push_back(s);
            end
            if (rows[i].burst) begin
                status_read(st);
                check("status busy during burst", st[7], 1'b1);
            end else begin
                wait_idle(); // burst strobes are checked with the next row
                compare_strobes();
                if (rows[i].gsel != 4'd0)
                    check($sformatf("global %0d", rows[i].gsel), global_out(rows[i].gsel),
                          rows[i].gexp);
            end
            report_test($sformatf("row %0d reg %02h", i, rows[i].regn), errs);
        end

        errs = errors;
        wait_idle();
        axi_write(1'b0, 1'b0, REG_CLKB, 4'h1, resp);
        check("bresp address slot", resp, RESP_OKAY);
        axi_write(1'b0, 1'b1, 8'h99, 4'h0, resp); // no byte lane
        check("bresp without byte lane", resp, RESP_SLVERR);
        status_read(st);
        check("status after dropped write", st, 8'h00);
        check("value_b", value_b, 8'h5C);
        compare_strobes();
        report_test("write without byte lane", errs);

        // busy ends on the 32nd enable and so has one enable period of phase slack
        errs = errors;
        wait_idle();
        fork
            write_register(1'b0, REG_CLKB, 8'h5C);
            measure_busy(len);
        join
        check($sformatf("busy length %0d clk at divide 6", len),
              len > (BUSY_ENABLES - 1) * 6 && len <= BUSY_ENABLES * 6, 1'b1);
        write_register(1'b0, REG_CLK_N2, 8'h00);
        wait_idle();
        fork
            write_register(1'b0, REG_CLKB, 8'h5C);
            measure_busy(len);
        join
        check($sformatf("busy length %0d clk at divide 2", len),
              len > (BUSY_ENABLES - 1) * 2 && len <= BUSY_ENABLES * 2, 1'b1);
        wait_idle();
        compare_strobes();
        report_test("busy length", errs);

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 tests, failed, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- all.f
fm_chip_pkg.sv
fm_bus_pkg.sv
reg_write_if.sv
axil_reg_port.sv
reg_write_queue.sv
chip_clk_div.sv
reg_decoder.sv
fm_reg_top.sv
tb_fm_reg.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_fm_reg
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := sim failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); \
	if [ $$st -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
